// ==== rtl/spectrum_pkg.sv ====
`default_nettype none

package spectrum_pkg;

  localparam int SAMPLE_W  = 16;             // one signed fft component
  localparam int POWER_W   = 32;             // re^2 + im^2 tops out at 2^31
  localparam int MAG_W     = POWER_W / 2;    // root of a POWER_W word
  localparam int FRAME_LEN = 256;            // fft transform length
  localparam int HALF_LEN  = FRAME_LEN / 2;  // real input gives a mirrored spectrum
  localparam int BUF_DEPTH = HALF_LEN;       // one whole half frame fits

  // one beat of the fft output stream
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;
    logic signed [SAMPLE_W-1:0] im;
    logic                       sop;
    logic                       eop;
    logic                       valid;
  } fft_sample_t;

  // one beat out of the power pipeline
  typedef struct packed {
    logic [POWER_W-1:0] power;
    logic               valid;
  } power_t;

endpackage

`default_nettype wire

// ==== rtl/power_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module power_calc (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spectrum_pkg::fft_sample_t sample,
  output spectrum_pkg::power_t      power
);

  import spectrum_pkg::*;

  logic [SAMPLE_W-1:0] abs_re;  // unsigned, so -32768 becomes 32768
  logic [SAMPLE_W-1:0] abs_im;
  logic                valid_s1;
  logic [POWER_W-1:0]  sum_q;
  logic                valid_s2;

  // valid travels alongside both stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      valid_s1 <= sample.valid;
      valid_s2 <= valid_s1;
    end
  end

  always_ff @(posedge clk) begin
    // stage 1 turns two's complement into magnitude
    abs_re <= sample.re[SAMPLE_W-1] ? (~sample.re + 1'b1) : sample.re;
    abs_im <= sample.im[SAMPLE_W-1] ? (~sample.im + 1'b1) : sample.im;
    // stage 2 registers the sum of squares
    sum_q  <= POWER_W'(abs_re) * POWER_W'(abs_re) +
              POWER_W'(abs_im) * POWER_W'(abs_im);
  end

  assign power = '{power: sum_q, valid: valid_s2};

endmodule

`default_nettype wire

// ==== rtl/capture_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_window (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  spectrum_pkg::fft_sample_t sample,
  output logic                      keep
);

  import spectrum_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,    // start seen, waiting on sop
    ST_CAPTURE
  } state_t;

  state_t                      state;
  logic [$clog2(HALF_LEN)-1:0] beat_cnt;  // valid beats taken so far
  logic                        last_beat;
  logic                        keep_raw;
  logic                        keep_d1;

  assign last_beat = (beat_cnt == $bits(beat_cnt)'(HALF_LEN - 1));

  // decision for the beat on the input this cycle
  always_comb begin
    case (state)
      ST_ARMED:   keep_raw = sample.valid && sample.sop;
      ST_CAPTURE: keep_raw = sample.valid;
      default:    keep_raw = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) state <= ST_ARMED;  // start only counts here
        end
        ST_ARMED: begin
          if (sample.valid && sample.sop) begin
            state    <= ST_CAPTURE;
            beat_cnt <= $bits(beat_cnt)'(1);  // sop beat is bin 0
          end
        end
        ST_CAPTURE: begin
          if (sample.valid) begin
            if (last_beat) begin
              // half frame done, rest of the frame is dropped
              state    <= ST_IDLE;
              beat_cnt <= '0;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // two stages to match the power pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      keep_d1 <= 1'b0;
      keep    <= 1'b0;
    end else begin
      keep_d1 <= keep_raw;
      keep    <= keep_d1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bin_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bin_buffer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  spectrum_pkg::power_t             power,
  input  logic                             keep,
  input  logic                             busy,
  output logic                             load,
  output logic [spectrum_pkg::POWER_W-1:0] operand
);

  import spectrum_pkg::*;

  logic [POWER_W-1:0]             mem [BUF_DEPTH];
  logic [$clog2(BUF_DEPTH)-1:0]   wr_ptr;   // wraps on its own, depth is 2^n
  logic [$clog2(BUF_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(BUF_DEPTH+1)-1:0] count;    // words held
  logic                           load_q;
  logic                           wr_en;

  assign wr_en = power.valid && keep;

  // load_q covers the cycle before busy goes high
  assign load    = (count != '0) && !busy && !load_q;
  assign operand = mem[rd_ptr];  // head word, read as it pops

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= power.power;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      load_q <= 1'b0;
    end else begin
      load_q <= load;
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (load)  rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, load})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/isqrt_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module isqrt_seq (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             load,
  input  logic [spectrum_pkg::POWER_W-1:0] operand,
  output logic                             busy,
  output logic [spectrum_pkg::MAG_W-1:0]   root,
  output logic                             done
);

  import spectrum_pkg::*;

  logic [POWER_W-1:0]        radicand;  // shifts out two bits per step
  logic [MAG_W+1:0]          rem;       // partial remainder, always >= 0
  logic [MAG_W-1:0]          quot;      // root bits resolved so far
  logic [$clog2(MAG_W)-1:0]  step;
  logic                      accept;
  logic                      last_step;
  logic [MAG_W+1:0]          shifted;
  logic [MAG_W+2:0]          trial;     // extra top bit is the sign
  logic [MAG_W-1:0]          next_quot;

  assign accept    = load && !busy;
  assign last_step = (step == $bits(step)'(MAG_W - 1));

  // bring down the next bit pair and try subtracting 4q+1
  assign shifted   = {rem[MAG_W-1:0], radicand[POWER_W-1 -: 2]};
  assign trial     = {1'b0, shifted} - {1'b0, quot, 2'b01};
  assign next_quot = {quot[MAG_W-2:0], ~trial[MAG_W+2]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      step <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;  // MAG_W+1 cycles after load
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      radicand <= operand;
      rem      <= '0;
      quot     <= '0;
    end else if (busy) begin
      radicand <= radicand << 2;
      // restore by keeping the shifted value when the trial goes negative
      rem      <= trial[MAG_W+2] ? shifted : trial[MAG_W+1:0];
      quot     <= next_quot;
      if (last_step) root <= next_quot;  // holds until the next result
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spectrum_magnitude.sv ====
`timescale 1ns/1ps
`default_nettype none

module spectrum_magnitude (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  spectrum_pkg::fft_sample_t      sample,
  output logic [spectrum_pkg::MAG_W-1:0] magnitude,
  output logic                           mag_valid
);

  import spectrum_pkg::*;

  power_t             power;    // every beat, 2 cycles late
  logic               keep;     // same alignment as power
  logic               busy;
  logic               load;
  logic [POWER_W-1:0] operand;

  power_calc u_power_calc (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (sample),
    .power  (power)
  );

  // runs beside the power pipeline on the same stream
  capture_window u_capture_window (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .sample (sample),
    .keep   (keep)
  );

  bin_buffer u_bin_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .power   (power),
    .keep    (keep),
    .busy    (busy),
    .load    (load),
    .operand (operand)
  );

  isqrt_seq u_isqrt_seq (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .operand (operand),
    .busy    (busy),
    .root    (magnitude),
    .done    (mag_valid)  // one pulse per bin
  );

endmodule

`default_nettype wire

// ==== verification/tb_spectrum_magnitude.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spectrum_magnitude;

  import spectrum_pkg::*;

  localparam int SEED         = 42569;
  localparam int NUM_CAPTURES = 4;
  localparam int MAX_CYCLES   = NUM_CAPTURES * HALF_LEN * (MAG_W + 3) +
                                6 * 2 * FRAME_LEN + 2000;

  logic              clk;
  logic              rst_n;
  logic              start;
  fft_sample_t       sample;
  logic [MAG_W-1:0]  magnitude;
  logic              mag_valid;

  // expected magnitudes in bin order, written as beats are driven
  logic [MAG_W-1:0]  exp_mem [NUM_CAPTURES*HALF_LEN];
  logic [MAG_W-1:0]  exp_now;
  logic              pending;
  int                wr_idx;
  int                rd_idx = 0;
  int                result_cnt = 0;
  int                cycle_cnt = 0;
  int                value_errs;
  int                protocol_errs;
  int                count_errs;

  spectrum_magnitude uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .sample    (sample),
    .magnitude (magnitude),
    .mag_valid (mag_valid)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  assign exp_now = exp_mem[rd_idx];
  assign pending = (wr_idx != rd_idx);

  always @(posedge clk) begin
    if (mag_valid) result_cnt <= result_cnt + 1;
    if (mag_valid && pending) rd_idx <= rd_idx + 1;  // next bin
  end

  value_matches: assert property (@(posedge clk) disable iff (!rst_n)
      mag_valid && pending |-> magnitude == exp_now)
    else begin
      value_errs++;
      $display("ERROR %0t magnitude expected %0d got %0d",
               $time, $sampled(exp_now), $sampled(magnitude));
    end

  // covers frames without start and the second half of each frame
  no_extra_result: assert property (@(posedge clk) disable iff (!rst_n)
      mag_valid |-> pending)
    else begin
      protocol_errs++;
      $display("%0t mag_valid pulsed while no captured bin was outstanding", $time);
    end

  single_cycle_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      mag_valid |=> !mag_valid)
    else begin
      protocol_errs++;
      $display("%0t mag_valid stayed high for more than one cycle", $time);
    end

  quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !mag_valid)
    else begin
      protocol_errs++;
      $display("ERROR %0t mag_valid expected 0 got %0b", $time, $sampled(mag_valid));
    end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("run timed out after %0d cycles with results still missing", cycle_cnt);
      $display("test failed");
      $finish;
    end
  end

  // floor of the root by bisection keeping lo*lo <= p < hi*hi
  function automatic int unsigned ref_sqrt(input longint unsigned p);
    longint unsigned lo;
    longint unsigned hi;
    longint unsigned mid;
    lo = 0;
    hi = 65536;
    while (hi - lo > 1) begin
      mid = (lo + hi) / 2;
      if (mid * mid <= p) lo = mid;
      else hi = mid;
    end
    return int'(lo);
  endfunction

  function automatic int rand_component();
    int pick;
    pick = $urandom % 8;
    if (pick == 0) return -32768;  // extremes show up often
    else if (pick == 1) return 32767;
    else return int'($signed(16'($urandom)));
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      sample <= '0;
      start  <= 1'b0;
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    idle_cycles(3);
  endtask

  // one frame of FRAME_LEN valid beats; capture pushes the first HALF_LEN
  task automatic send_frame(input bit capture, input bit gaps, input bit corners,
                            input bit stray_start);
    int n;
    int re_v;
    int im_v;
    longint unsigned p;
    int corner_re [4] = '{0, -32768, 32767, -32768};
    int corner_im [4] = '{0, -32768, 32767, 32767};
    n = 0;
    if (capture) pulse_start();
    while (n < FRAME_LEN) begin
      if (gaps && ($urandom % 4 == 0)) begin
        @(posedge clk);
        sample <= '{re: 16'($urandom), im: 16'($urandom), sop: 1'b0, eop: 1'b0,
                    valid: 1'b0};
        start  <= 1'b0;
      end else begin
        if (corners && n < 4) begin
          re_v = corner_re[n];
          im_v = corner_im[n];
        end else begin
          re_v = rand_component();
          im_v = rand_component();
        end
        @(posedge clk);
        sample <= '{re: 16'(re_v), im: 16'(im_v), sop: (n == 0),
                    eop: (n == FRAME_LEN - 1), valid: 1'b1};
        start  <= stray_start && (n == 40);  // window is busy so this start is ignored
        if (capture && n < HALF_LEN) begin
          p = longint'(re_v) * re_v + longint'(im_v) * im_v;
          exp_mem[wr_idx] = MAG_W'(ref_sqrt(p));
          wr_idx++;
        end
        n++;
      end
    end
    idle_cycles(1);
  endtask

  task automatic wait_drained(input int captures);
    while (rd_idx != wr_idx) @(posedge clk);
    idle_cycles(3 * (MAG_W + 3));  // room for any extra result to show
    assert (result_cnt == captures * HALF_LEN)
      else begin
        count_errs++;
        $display("ERROR %0t result_cnt expected %0d got %0d",
                 $time, captures * HALF_LEN, result_cnt);
      end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n         = 1'b0;
    start         = 1'b0;
    sample        = '0;
    wr_idx        = 0;
    value_errs    = 0;
    protocol_errs = 0;
    count_errs    = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    idle_cycles(5);
    send_frame(1'b0, 1'b0, 1'b0, 1'b0);  // no start so nothing may come out
    idle_cycles(50);
    send_frame(1'b1, 1'b0, 1'b1, 1'b0);  // zero and full scale bins first
    wait_drained(1);
    send_frame(1'b1, 1'b1, 1'b0, 1'b1);  // gaps and a stray start
    wait_drained(2);
    send_frame(1'b1, 1'b1, 1'b0, 1'b0);
    wait_drained(3);
    send_frame(1'b1, 1'b0, 1'b0, 1'b0);
    send_frame(1'b0, 1'b1, 1'b0, 1'b0);  // follows straight on without a start
    wait_drained(4);
    $display("errors: value %0d, protocol %0d, count %0d",
             value_errs, protocol_errs, count_errs);
    if (value_errs + protocol_errs + count_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/spectrum_pkg.sv
rtl/power_calc.sv
rtl/capture_window.sv
rtl/bin_buffer.sv
rtl/isqrt_seq.sv
rtl/spectrum_magnitude.sv
verification/tb_spectrum_magnitude.sv
